// File: source/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word;	// one raw instruction word
	typedef logic [2:0] lc3b_reg;	// register number r0..r7

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,	// conditional branch on nzp
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,	// load byte
		op_stb  = 4'b0011,	// store byte
		op_jsr  = 4'b0100,	// jsr / jsrr, bit 11 selects
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,	// load word, base + offset
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,	// load indirect
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,	// jmp / ret
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef struct packed
	{
		lc3b_opcode opcode;	// [15:12]
		lc3b_reg dr;		// [11:9] dest, or store data
		lc3b_reg sr1;		// [8:6] source 1 or base
		logic mode;		// [5] imm select for add/and
		logic [1:0] unused;	// [4:3]
		lc3b_reg sr2;		// [2:0]
	} reg_fmt_t;

	typedef struct packed
	{
		lc3b_opcode opcode;	// [15:12]
		logic n;		// [11]
		logic z;		// [10]
		logic p;		// [9]
		logic [8:0] offset;	// pc-relative offset
	} br_fmt_t;

	// same 16 bits, read as register fields or as a branch
	typedef union packed
	{
		reg_fmt_t reg_view;	// operand decode
		br_fmt_t br_view;	// redirect decode
	} instr_u;

endpackage

// File: source/hazard_pkg.sv
package hazard_pkg;

	typedef logic [2:0] count_t;	// redirect countdown

	localparam count_t REDIRECT_COUNT = 3'd5;	// four bubbles + squash decision

	typedef struct packed
	{
		logic writes_dr;	// result goes to the dr field
		logic reads_sr1;	// sr1 field is a source
		logic reads_sr2;	// sr2 field is a source
		logic reads_dr;		// dr field read as store data
	} operand_use_t;

	typedef struct packed
	{
		logic bubble;	// insert nop into id/ex
		logic squash;	// kill wrong-path instr in id
	} redirect_t;

	typedef struct packed
	{
		logic gen_bubble;	// final bubble request
		logic squash_id;	// final squash request
	} hazard_ctrl_t;

endpackage

// File: source/operand_decode.sv
`timescale 1ns/10ps

module operand_decode
(
	input lc3b_isa_pkg::instr_u ir,
	output hazard_pkg::operand_use_t uses
);

	always_comb
	begin
		uses = '0;	// reads nothing and writes nothing unless decoded
		case (ir.reg_view.opcode)
			lc3b_isa_pkg::op_add,
			lc3b_isa_pkg::op_and:
			begin
				uses.writes_dr = 1'b1;
				uses.reads_sr1 = 1'b1;
				uses.reads_sr2 = ~ir.reg_view.mode;	// sr2 only in register mode
			end
			lc3b_isa_pkg::op_not,
			lc3b_isa_pkg::op_shf:
			begin
				uses.writes_dr = 1'b1;
				uses.reads_sr1 = 1'b1;	// single source
			end
			lc3b_isa_pkg::op_ldb,
			lc3b_isa_pkg::op_ldr,
			lc3b_isa_pkg::op_ldi:
			begin
				uses.writes_dr = 1'b1;	// loaded value
				uses.reads_sr1 = 1'b1;	// base reg
			end
			lc3b_isa_pkg::op_lea:
				uses.writes_dr = 1'b1;	// pc relative, no source
			lc3b_isa_pkg::op_stb,
			lc3b_isa_pkg::op_str,
			lc3b_isa_pkg::op_sti:
			begin
				uses.reads_sr1 = 1'b1;	// base reg
				uses.reads_dr = 1'b1;	// store data sits in dr field
			end
			lc3b_isa_pkg::op_jmp:
				uses.reads_sr1 = 1'b1;	// target base
			lc3b_isa_pkg::op_jsr:
				uses.reads_sr1 = ~ir.reg_view.dr[2];	// jsrr when bit 11 low
			default:
				uses = '0;	// br, trap, rti touch no gp operand
		endcase
	end

endmodule

// File: source/load_use_detect.sv
`timescale 1ns/10ps

module load_use_detect
(
	input lc3b_isa_pkg::instr_u if_id_ir,
	input lc3b_isa_pkg::instr_u id_ex_ir,
	output logic load_use
);

	hazard_pkg::operand_use_t if_id_use;	// what the id instr reads
	hazard_pkg::operand_use_t id_ex_use;	// what the ex instr writes
	lc3b_isa_pkg::lc3b_reg load_dr;		// ex load destination
	logic id_ex_is_load;
	logic sr1_hit;
	logic sr2_hit;
	logic dr_hit;

	operand_decode if_id_deps
	(
		.ir(if_id_ir),
		.uses(if_id_use)
	);

	operand_decode id_ex_deps
	(
		.ir(id_ex_ir),
		.uses(id_ex_use)
	);

	assign load_dr = id_ex_ir.reg_view.dr;

	// only memory loads need the extra cycle, alu results forward
	assign id_ex_is_load = ((id_ex_ir.reg_view.opcode == lc3b_isa_pkg::op_ldb) ||
		(id_ex_ir.reg_view.opcode == lc3b_isa_pkg::op_ldi) ||
		(id_ex_ir.reg_view.opcode == lc3b_isa_pkg::op_ldr)) &&
		id_ex_use.writes_dr;	// qualify with decoded write

	assign sr1_hit = if_id_use.reads_sr1 && (if_id_ir.reg_view.sr1 == load_dr);	// base or src1
	assign sr2_hit = if_id_use.reads_sr2 && (if_id_ir.reg_view.sr2 == load_dr);	// reg mode src2
	assign dr_hit = if_id_use.reads_dr && (if_id_ir.reg_view.dr == load_dr);	// store data

	assign load_use = id_ex_is_load && (sr1_hit || sr2_hit || dr_hit);

endmodule

// File: source/redirect_sequencer.sv
`timescale 1ns/10ps

module redirect_sequencer
(
	input logic clk,
	input logic reset,
	input lc3b_isa_pkg::instr_u if_id_ir,
	input logic branch_enable,
	input logic flow_id_ex,
	output hazard_pkg::redirect_t redirect
);

	hazard_pkg::count_t counter;		// bubbles left in sequence
	hazard_pkg::count_t counter_next;
	lc3b_isa_pkg::instr_u last_ir;		// instr that started the sequence
	logic br_taken_q;			// branch enable from last advance
	logic if_id_redirect;			// pc-changing instr in id
	logic last_is_lea;
	logic last_is_br;
	logic bubble;
	logic squash;

	// a zero word is a flushed slot and never a redirect
	always_comb
	begin
		if_id_redirect = 1'b0;
		if (lc3b_isa_pkg::lc3b_word'(if_id_ir) != '0)
		begin
			case (if_id_ir.br_view.opcode)
				lc3b_isa_pkg::op_br,
				lc3b_isa_pkg::op_jmp,
				lc3b_isa_pkg::op_jsr,
				lc3b_isa_pkg::op_trap:
					if_id_redirect = 1'b1;	// target not known until mem
				default:
					if_id_redirect = 1'b0;
			endcase
		end
	end

	assign last_is_lea = (last_ir.br_view.opcode == lc3b_isa_pkg::op_lea);
	assign last_is_br = (last_ir.br_view.opcode == lc3b_isa_pkg::op_br);

	always_comb
	begin
		counter_next = counter;	// hold by default
		if (counter == '0)
		begin
			if (if_id_redirect || last_is_lea)
				counter_next = hazard_pkg::REDIRECT_COUNT;	// start countdown
		end
		else
			counter_next = counter - 1'b1;	// count down toward decision
	end

	// lea keeps bubbling for the whole count, including the load cycle
	assign bubble = (counter > 3'd1) || last_is_lea;

	// at count one the target is resolved; not-taken br keeps the id instr
	assign squash = (counter == 3'd1) && !last_is_lea &&
		(!last_is_br || br_taken_q);

	assign redirect.bubble = bubble;
	assign redirect.squash = squash;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			counter <= '0;
			last_ir <= '0;
			br_taken_q <= 1'b0;
		end
		else if (flow_id_ex)	// every update waits for pipeline advance
		begin
			br_taken_q <= branch_enable;
			if (!bubble)
				last_ir <= if_id_ir;	// frozen while bubbling
			counter <= counter_next;
		end
	end

endmodule

// File: source/hazard_merge.sv
`timescale 1ns/10ps

module hazard_merge
(
	input logic load_use,
	input hazard_pkg::redirect_t redirect,
	output hazard_pkg::hazard_ctrl_t hazard
);

	logic load_bubble;	// load-use bubble after squash masking

	// squashed instr never reaches ex, so its load-use stall is moot
	assign load_bubble = load_use && !redirect.squash;

	always_comb
	begin
		hazard.squash_id = redirect.squash;	// redirect decides squash alone
		hazard.gen_bubble = redirect.bubble || load_bubble;	// either source stalls
	end

endmodule

// File: source/bubbler.sv
`timescale 1ns/10ps

module bubbler
(
	input logic clk,
	input logic reset,
	input lc3b_isa_pkg::instr_u if_id_ir,
	input lc3b_isa_pkg::instr_u id_ex_ir,
	input logic branch_enable,
	input logic flow_id_ex,
	output hazard_pkg::hazard_ctrl_t hazard
);

	logic load_use;				// raw load-use match
	hazard_pkg::redirect_t redirect;	// sequencer bubble / squash

	load_use_detect lu0
	(
		.if_id_ir(if_id_ir),
		.id_ex_ir(id_ex_ir),
		.load_use(load_use)
	);

	redirect_sequencer rs0
	(
		.clk(clk),
		.reset(reset),
		.if_id_ir(if_id_ir),
		.branch_enable(branch_enable),
		.flow_id_ex(flow_id_ex),
		.redirect(redirect)
	);

	hazard_merge hm0
	(
		.load_use(load_use),
		.redirect(redirect),
		.hazard(hazard)
	);

endmodule

// File: testbench/bubbler_sva.sv
`timescale 1ns/10ps

module bubbler_sva
(
	input logic clk,
	input logic reset,
	input logic flow_id_ex,
	input hazard_pkg::count_t counter,
	input hazard_pkg::redirect_t redirect
);

	count_bound: assert property (@(posedge clk) disable iff (reset)
		counter <= hazard_pkg::REDIRECT_COUNT)	// load value is the ceiling
		else $error("redirect counter above its load value");

	count_hold: assert property (@(posedge clk) disable iff (reset)
		!flow_id_ex |=> (counter == $past(counter)))	// frozen pipeline
		else $error("redirect counter moved without an advance");

	// decision point only reached by counting down from two
	squash_at_one: assert property (@(posedge clk) disable iff (reset)
		redirect.squash |-> ($past(counter) inside {3'd1, 3'd2}))
		else $error("squash outside the count-one decision point");

	// merge masks load use under squash, so top gen_bubble then equals this bubble
	squash_no_bubble: assert property (@(posedge clk) disable iff (reset)
		redirect.squash |-> !redirect.bubble)
		else $error("bubble and squash raised together");

endmodule

bind redirect_sequencer bubbler_sva sva0
(
	.clk(clk),
	.reset(reset),
	.flow_id_ex(flow_id_ex),
	.counter(counter),
	.redirect(redirect)
);

// File: testbench/bubbler_tb.sv
`timescale 1ns/10ps

module bubbler_tb;

	logic clk;
	logic reset;
	lc3b_isa_pkg::instr_u if_id_ir;
	lc3b_isa_pkg::instr_u id_ex_ir;
	logic branch_enable;
	logic flow_id_ex;
	hazard_pkg::hazard_ctrl_t hazard;

	logic [31:0] lfsr_state = 32'ha3f027f2;
	logic [63:0] op_table = 64'hED9F_4C0B_3715_1A26;	// class -> opcode nibble
	hazard_pkg::count_t m_count;	// model countdown
	lc3b_isa_pkg::instr_u m_last;	// model held instr
	logic m_br_taken;		// model latched branch enable
	int cycle_count = 0;
	int seg_count = 30;		// random segments with a short reset before each
	int seg_len = 60;
	int cycle_limit;

	bubbler dut0
	(
		.clk(clk),
		.reset(reset),
		.if_id_ir(if_id_ir),
		.id_ex_ir(id_ex_ir),
		.branch_enable(branch_enable),
		.flow_id_ex(flow_id_ex),
		.hazard(hazard)
	);

	always #10 clk = ~clk;	// 20 ns period

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: run went past %0d cycles without finishing", cycle_limit);
			$display("Verification failed");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];	// x^32 + x^22 + x^2 + x + 1
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};	// one step per bit
		end
	endtask

	function automatic lc3b_isa_pkg::instr_u make_instr(input lc3b_isa_pkg::lc3b_opcode op,
		input logic [2:0] dr, input logic [2:0] sr1, input logic mode, input logic [2:0] sr2);
		lc3b_isa_pkg::instr_u w;
		w.reg_view.opcode = op;
		w.reg_view.dr = dr;	// nzp for br
		w.reg_view.sr1 = sr1;
		w.reg_view.mode = mode;
		w.reg_view.unused = 2'b00;
		w.reg_view.sr2 = sr2;
		return w;
	endfunction

	// reference operand table in writes_dr reads_sr1 reads_sr2 reads_dr order
	function automatic hazard_pkg::operand_use_t expected_uses(input lc3b_isa_pkg::instr_u ir);
		hazard_pkg::operand_use_t u;
		case (ir.reg_view.opcode)
			lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and:
				u = {1'b1, 1'b1, ~ir.reg_view.mode, 1'b0};	// imm form skips sr2
			lc3b_isa_pkg::op_not, lc3b_isa_pkg::op_shf, lc3b_isa_pkg::op_ldb,
			lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_ldi:
				u = 4'b1100;
			lc3b_isa_pkg::op_lea:
				u = 4'b1000;
			lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_sti:
				u = 4'b0101;	// base + store data
			lc3b_isa_pkg::op_jmp:
				u = 4'b0100;
			lc3b_isa_pkg::op_jsr:
				u = {1'b0, ~ir.reg_view.dr[2], 2'b00};	// jsrr reads base
			default:
				u = '0;
		endcase
		return u;
	endfunction

	function automatic logic expected_load_use(input lc3b_isa_pkg::instr_u id,
		input lc3b_isa_pkg::instr_u ex);
		hazard_pkg::operand_use_t u;
		logic is_load;
		u = expected_uses(id);
		is_load = (ex.reg_view.opcode inside {lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_ldi,
			lc3b_isa_pkg::op_ldr});
		return is_load && ((u.reads_sr1 && id.reg_view.sr1 == ex.reg_view.dr) ||
			(u.reads_sr2 && id.reg_view.sr2 == ex.reg_view.dr) ||
			(u.reads_dr && id.reg_view.dr == ex.reg_view.dr));
	endfunction

	function automatic logic starts_redirect(input lc3b_isa_pkg::instr_u ir);
		return (ir != '0) && (ir.br_view.opcode inside {lc3b_isa_pkg::op_br,
			lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_trap});
	endfunction

	task automatic check_ctrl(input string name, input hazard_pkg::hazard_ctrl_t exp,
		input hazard_pkg::hazard_ctrl_t act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_redirect(input string name, input hazard_pkg::redirect_t exp,
		input hazard_pkg::redirect_t act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// called 2 ns after a rising edge and returns 2 ns after the next one
	task automatic step(input lc3b_isa_pkg::instr_u ifid, input lc3b_isa_pkg::instr_u idex,
		input logic be, input logic flow);
		hazard_pkg::redirect_t exp_r;
		hazard_pkg::hazard_ctrl_t exp_c;
		logic last_lea;
		logic start;
		if_id_ir = ifid;
		id_ex_ir = idex;
		branch_enable = be;
		flow_id_ex = flow;
		last_lea = (m_last.br_view.opcode == lc3b_isa_pkg::op_lea);
		exp_r.bubble = (m_count > 3'd1) || last_lea;	// lea bubbles at every count
		exp_r.squash = (m_count == 3'd1) && !last_lea &&
			((m_last.br_view.opcode != lc3b_isa_pkg::op_br) || m_br_taken);
		exp_c.squash_id = exp_r.squash;
		exp_c.gen_bubble = exp_r.bubble || (expected_load_use(ifid, idex) && !exp_r.squash);
		#16;	// sample just before the edge
		check_redirect("dut0.rs0.redirect", exp_r, dut0.rs0.redirect);
		check_ctrl("hazard", exp_c, hazard);
		@(posedge clk);
		if (flow)
		begin
			start = (m_count == '0) && (starts_redirect(ifid) || last_lea);
			if (!exp_r.bubble)
				m_last = ifid;	// held while bubbling
			m_br_taken = be;
			if (start)
				m_count = hazard_pkg::REDIRECT_COUNT;
			else if (m_count != '0)
				m_count = m_count - 3'd1;
		end
		#2;
	endtask

	task automatic advance_idle(input int n, input logic be);
		repeat (n) step('0, '0, be, 1'b1);	// flushed slots
	endtask

	task automatic reset_dut(input int n);
		reset = 1'b1;
		if_id_ir = '0;
		id_ex_ir = '0;
		branch_enable = 1'b0;
		flow_id_ex = 1'b0;
		repeat (n) @(posedge clk);
		m_count = '0;
		m_last = '0;
		m_br_taken = 1'b0;
		#2;
		reset = 1'b0;
	endtask

	task automatic random_instr(output lc3b_isa_pkg::instr_u ir);
		logic [31:0] cls;
		logic [31:0] raw;
		logic [31:0] regs;
		logic [31:0] pick;
		take_bits(4, cls);
		take_bits(16, raw);
		take_bits(7, regs);
		take_bits(1, pick);
		ir = raw[15:0];	// offsets and unused bits stay random
		ir.reg_view.opcode = lc3b_isa_pkg::lc3b_opcode'(op_table[{cls[3:0], 2'b00} +: 4]);
		ir.reg_view.dr = {raw[11] & regs[6], regs[1:0]};	// mostly r0..r3 for more hits
		ir.reg_view.sr1 = {1'b0, regs[3:2]};
		ir.reg_view.sr2 = {1'b0, regs[5:4]};
		if (cls[3:0] == 4'd9 && pick[0])
			ir = '0;	// half the br class becomes a flushed slot
	endtask

	task automatic random_step();
		lc3b_isa_pkg::instr_u a;
		lc3b_isa_pkg::instr_u b;
		logic [31:0] be;
		logic [31:0] fl;
		random_instr(a);
		random_instr(b);
		take_bits(1, be);
		take_bits(2, fl);
		step(a, b, be[0], fl[1:0] != 2'b00);	// advance about 3/4 of cycles
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		if_id_ir = '0;
		id_ex_ir = '0;
		branch_enable = 1'b0;
		flow_id_ex = 1'b0;
		cycle_limit = 10 + 75 + seg_count * (seg_len + 2) + 100;	// reset, 75 directed cycles
		reset_dut(10);
		// load-use through sr1, sr2, store data, then misses
		step(make_instr(lc3b_isa_pkg::op_add, 1, 3, 0, 2),
			make_instr(lc3b_isa_pkg::op_ldr, 3, 5, 0, 0), 1'b0, 1'b1);
		step(make_instr(lc3b_isa_pkg::op_add, 1, 4, 0, 3),
			make_instr(lc3b_isa_pkg::op_ldb, 3, 5, 0, 0), 1'b0, 1'b1);
		step(make_instr(lc3b_isa_pkg::op_str, 3, 5, 0, 0),
			make_instr(lc3b_isa_pkg::op_ldi, 3, 6, 0, 0), 1'b0, 1'b1);
		step(make_instr(lc3b_isa_pkg::op_add, 1, 4, 0, 5),
			make_instr(lc3b_isa_pkg::op_ldr, 3, 5, 0, 0), 1'b0, 1'b1);
		step(make_instr(lc3b_isa_pkg::op_add, 1, 4, 1, 3),
			make_instr(lc3b_isa_pkg::op_ldr, 3, 5, 0, 0), 1'b0, 1'b1);	// imm field
		step(make_instr(lc3b_isa_pkg::op_add, 1, 3, 0, 2),
			make_instr(lc3b_isa_pkg::op_add, 3, 5, 0, 0), 1'b0, 1'b1);	// alu producer
		// not-taken then taken br
		step(make_instr(lc3b_isa_pkg::op_br, 3'b010, 0, 1, 4), '0, 1'b0, 1'b1);
		advance_idle(5, 1'b0);
		step(make_instr(lc3b_isa_pkg::op_br, 3'b111, 2, 0, 1), '0, 1'b1, 1'b1);
		advance_idle(5, 1'b1);
		// unconditional redirects
		step(make_instr(lc3b_isa_pkg::op_jmp, 0, 2, 0, 0), '0, 1'b0, 1'b1);
		advance_idle(5, 1'b0);
		step(make_instr(lc3b_isa_pkg::op_jsr, 3'b100, 0, 0, 7), '0, 1'b0, 1'b1);
		advance_idle(5, 1'b0);
		step(make_instr(lc3b_isa_pkg::op_trap, 0, 0, 1, 5), '0, 1'b0, 1'b1);
		advance_idle(5, 1'b0);
		advance_idle(3, 1'b0);	// zero word starts nothing
		// freeze mid countdown
		step(make_instr(lc3b_isa_pkg::op_br, 3'b001, 0, 0, 2), '0, 1'b1, 1'b1);
		repeat (4) step('0, '0, 1'b1, 1'b0);
		advance_idle(5, 1'b1);
		// load-use match in the squash cycle
		step(make_instr(lc3b_isa_pkg::op_jmp, 0, 6, 0, 0), '0, 1'b0, 1'b1);
		advance_idle(4, 1'b0);
		step(make_instr(lc3b_isa_pkg::op_add, 1, 2, 0, 2),
			make_instr(lc3b_isa_pkg::op_ldr, 2, 5, 0, 0), 1'b0, 1'b1);
		advance_idle(1, 1'b0);
		// lea held in last_ir
		step(make_instr(lc3b_isa_pkg::op_lea, 4, 0, 0, 3), '0, 1'b0, 1'b1);
		advance_idle(8, 1'b0);
		reset_dut(2);
		// reset in mid countdown
		step(make_instr(lc3b_isa_pkg::op_trap, 0, 0, 0, 1), '0, 1'b0, 1'b1);
		advance_idle(2, 1'b0);
		reset_dut(2);
		advance_idle(3, 1'b0);
		for (int s = 0; s < seg_count; s++)
		begin
			reset_dut(2);	// held lea never clears by itself
			repeat (seg_len) random_step();
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// File: lc3b_hazard.f
source/lc3b_isa_pkg.sv
source/hazard_pkg.sv
source/operand_decode.sv
source/load_use_detect.sv
source/redirect_sequencer.sv
source/hazard_merge.sv
source/bubbler.sv
testbench/bubbler_sva.sv
testbench/bubbler_tb.sv
